// File: bench/axi_wr_cases.txt
# id addr len size burst(0 fixed 1 incr 2 wrap) data_base strobe resp(0 okay 2 slverr)
# All fields hex, one burst per line, beat data is data_base plus beat index
1 00000000 0 2 1 11110000 f 0
2 00000010 3 2 1 22220000 f 0
3 00000014 1 2 1 33330000 3 0
4 00000040 7 2 1 44440000 f 0
5 00000044 0 2 1 55550000 a 0
6 00000038 3 2 2 66660000 f 0
7 00000084 7 2 2 77770000 f 0
8 00000028 3 2 0 88880000 f 0
9 0000002c 2 2 0 99990000 c 0
a 00000100 0 2 1 aaaa0000 f 2
b 000000f8 3 2 1 bbbb0000 f 2
c 00000200 1 2 1 cccc0000 f 2
d 00000060 f 2 1 dddd0000 f 0
e 00000074 f 2 2 eeee0000 f 0
f 000000fc 0 2 1 ffff0000 5 0
0 00000000 1 2 1 12340000 f 0
3 000000f0 7 2 2 abcd0000 f 0
5 000000c8 1 2 0 5a5a0000 6 0

// File: axi_wr_sys.f
hdl/axi_pkg.sv
hdl/wr_mem_pkg.sv
hdl/skidbuffer.sv
hdl/axi_addr.sv
hdl/axi_sub_wr.sv
hdl/wr_mem_ep.sv
hdl/axi_wr_sys.sv
bench/axi_wr_checker.sv
bench/tb_axi_wr_sys.sv

// File: run_sim.sh
#!/usr/bin/env bash
# Build and run the testbench with Verilator from the project root
set -e

cd "$(dirname "$0")"

verilator --binary --timing -j 0 \
    --top-module tb_axi_wr_sys \
    -f axi_wr_sys.f \
    -o sim_axi_wr_sys

out="$(./obj_dir/sim_axi_wr_sys)"
echo "$out"

if grep -q "STATUS: PASS" <<< "$out"; then
    exit 0
fi
exit 1

// File: bench/tb_axi_wr_sys.sv
`timescale 1ns/1ps
`default_nettype none

module tb_axi_wr_sys import wr_mem_pkg::*;;

    localparam int DEPTH = MEM_WORDS;
    localparam int TMO   = 300;

    logic                 clk;
    logic                 rst_n;
    logic                 i_awvalid;
    logic                 o_awready;
    logic [31:0]          i_awaddr;
    logic [1:0]           i_awburst;
    logic [2:0]           i_awsize;
    logic [7:0]           i_awlen;
    logic [3:0]           i_awid;
    logic                 i_wvalid;
    logic                 o_wready;
    logic [31:0]          i_wdata;
    logic [3:0]           i_wstrb;
    logic                 i_wlast;
    logic                 o_bvalid;
    logic                 i_bready;
    logic [1:0]           o_bresp;
    logic [3:0]           o_bid;
    logic [MEM_IDX_W-1:0] i_rd_idx;
    logic [31:0]          o_rd_data;
    logic [15:0]          o_burst_cnt;

    // Reference image of the endpoint and which bytes hold known data
    logic [31:0] mdl   [DEPTH];
    logic [3:0]  known [DEPTH];
    bit          hung;
    int          issued;

    axi_wr_sys #(
        .DEPTH    (DEPTH),
        .HOLD_CYC (MEM_HOLD_DEF)
    ) axi_wr_sys_i (
        .clk         (clk),
        .rst_n       (rst_n),
        .i_awvalid   (i_awvalid),
        .o_awready   (o_awready),
        .i_awaddr    (i_awaddr),
        .i_awburst   (i_awburst),
        .i_awsize    (i_awsize),
        .i_awlen     (i_awlen),
        .i_awid      (i_awid),
        .i_wvalid    (i_wvalid),
        .o_wready    (o_wready),
        .i_wdata     (i_wdata),
        .i_wstrb     (i_wstrb),
        .i_wlast     (i_wlast),
        .o_bvalid    (o_bvalid),
        .i_bready    (i_bready),
        .o_bresp     (o_bresp),
        .o_bid       (o_bid),
        .i_rd_idx    (i_rd_idx),
        .o_rd_data   (o_rd_data),
        .o_burst_cnt (o_burst_cnt)
    );

    axi_wr_checker chk (
        .clk         (clk),
        .rst_n       (rst_n),
        .i_awready   (o_awready),
        .i_wready    (o_wready),
        .i_bvalid    (o_bvalid),
        .i_bready    (i_bready),
        .i_bresp     (o_bresp),
        .i_bid       (o_bid),
        .i_rd_data   (o_rd_data),
        .i_burst_cnt (o_burst_cnt)
    );

    initial begin
        clk = 1'b0;
        forever #4 clk = ~clk;
    end

    // Random B back-pressure with ready in about one cycle of four
    // Responses pile up behind the next burst this way
    initial begin
        @(posedge rst_n);
        forever begin
            @(posedge clk);
            #1 i_bready = (($urandom % 4) == 0);
        end
    end

    // ------------------------------------------------------------------------
    // AXI manager
    // ------------------------------------------------------------------------
    task automatic drive_aw(input logic [3:0] id, input logic [31:0] addr,
                            input logic [7:0] len, input logic [2:0] size,
                            input logic [1:0] burst);
        int t;
        begin
            @(posedge clk);
            #1;
            i_awvalid = 1'b1;
            i_awid    = id;
            i_awaddr  = addr;
            i_awlen   = len;
            i_awsize  = size;
            i_awburst = burst;
            t = 0;
            // Ready is a flop, so its value now holds until the next edge
            while (!o_awready && !hung) begin
                @(posedge clk);
                #1;
                t++;
                if (t >= TMO) begin
                    $display("AW channel never accepted burst id %0h", id);
                    hung = 1'b1;
                end
            end
            @(posedge clk);
            #1 i_awvalid = 1'b0;
        end
    endtask

    task automatic drive_w(input logic [7:0] len, input logic [31:0] base,
                           input logic [3:0] strb);
        int t;
        begin
            @(posedge clk);
            #1;
            for (int i = 0; i <= int'(len) && !hung; i++) begin
                // Occasional idle cycle between beats
                if (($urandom % 3) == 0) begin
                    @(posedge clk);
                    #1;
                end
                i_wvalid = 1'b1;
                i_wdata  = base + 32'(i);
                i_wstrb  = strb;
                i_wlast  = (i == int'(len));
                t = 0;
                while (!o_wready && !hung) begin
                    @(posedge clk);
                    #1;
                    t++;
                    if (t >= TMO) begin
                        $display("W channel stalled on beat %0d", i);
                        hung = 1'b1;
                    end
                end
                @(posedge clk);
                #1 i_wvalid = 1'b0;
            end
        end
    endtask

    task automatic wait_resp(input int target);
        int t;
        begin
            t = 0;
            while (chk.resp_cnt < target && !hung) begin
                @(posedge clk);
                #1;
                t++;
                if (t >= TMO) begin
                    $display("No write response arrived for burst %0d", target);
                    hung = 1'b1;
                end
            end
        end
    endtask

    // Final beat of the burst has reached the endpoint
    task automatic wait_commit(input int target);
        int t;
        begin
            t = 0;
            while (int'(o_burst_cnt) < target && !hung) begin
                @(posedge clk);
                #1;
                t++;
                if (t >= TMO) begin
                    $display("Final beat of burst %0d never reached the memory", target);
                    hung = 1'b1;
                end
            end
        end
    endtask

    // ------------------------------------------------------------------------
    // One burst with model update, drive and memory compare
    // ------------------------------------------------------------------------
    task automatic run_case(input int num, input logic [3:0] id, input logic [31:0] addr,
                            input logic [7:0] len, input logic [2:0] size,
                            input logic [1:0] burst, input logic [31:0] base,
                            input logic [3:0] strb, input logic [1:0] resp);
        logic [31:0] a;
        logic [31:0] d;
        logic [31:0] bytes;
        logic [31:0] win;
        logic [31:0] wbase;
        logic [31:0] bmask;
        int          widx;
        bit          err;
        int          e0;
        int          touched[$];
        begin
            a     = addr;
            bytes = 32'd1 << size;
            win   = bytes * (32'(len) + 32'd1);
            err   = 1'b0;
            e0    = chk.err_cnt;
            for (int i = 0; i <= int'(len); i++) begin
                d    = base + 32'(i);
                widx = int'(a >> 2);
                if (widx < DEPTH) begin
                    for (int b = 0; b < 4; b++) begin
                        if (strb[b]) begin
                            mdl[widx][b*8 +: 8] = d[b*8 +: 8];
                            known[widx][b]      = 1'b1;
                        end
                    end
                    touched.push_back(widx);
                end else begin
                    err = 1'b1;
                end
                // Address of the following beat
                if (burst == 2'd1) begin
                    a = a - (a % bytes) + bytes;
                end else if (burst == 2'd2) begin
                    wbase = a - (a % win);
                    a     = wbase + ((a - wbase + bytes) % win);
                end
            end
            // Dropped beats must not land anywhere else in the array
            if (err) begin
                touched.delete();
                for (int w = 0; w < DEPTH; w++) begin
                    if (known[w] != 4'h0) begin
                        touched.push_back(w);
                    end
                end
            end
            if ((err ? 2'b10 : 2'b00) != resp) begin
                chk.flag_error("Case file response disagrees with the address map");
            end
            chk.expect_resp(id, resp);
            issued++;
            fork
                drive_aw(id, addr, len, size, burst);
                drive_w(len, base, strb);
            join
            // The response may still wait on B while the next burst starts
            wait_commit(num);
            foreach (touched[k]) begin
                @(posedge clk);
                #1 i_rd_idx = MEM_IDX_W'(touched[k]);
                for (int b = 0; b < 4; b++) begin
                    bmask[b*8 +: 8] = {8{known[touched[k]][b]}};
                end
                #1 chk.check_word(touched[k], mdl[touched[k]], bmask);
            end
            chk.check_count(num);
            chk.end_case(num, id, e0);
        end
    endtask

    initial begin
        int          fd;
        int          n;
        int          case_no;
        string       line;
        logic [31:0] f_id;
        logic [31:0] f_addr;
        logic [31:0] f_len;
        logic [31:0] f_size;
        logic [31:0] f_burst;
        logic [31:0] f_base;
        logic [31:0] f_strb;
        logic [31:0] f_resp;
        n = $urandom(32'h8d21);
        hung      = 1'b0;
        issued    = 0;
        case_no   = 0;
        rst_n     = 1'b0;
        i_awvalid = 1'b0;
        i_awaddr  = '0;
        i_awburst = '0;
        i_awsize  = '0;
        i_awlen   = '0;
        i_awid    = '0;
        i_wvalid  = 1'b0;
        i_wdata   = '0;
        i_wstrb   = '0;
        i_wlast   = 1'b0;
        i_bready  = 1'b0;
        i_rd_idx  = '0;
        for (int w = 0; w < DEPTH; w++) begin
            mdl[w]   = '0;
            known[w] = '0;
        end
        repeat (5) @(posedge clk);
        #1 rst_n = 1'b1;
        @(posedge clk);
        #1 chk.check_idle();

        fd = $fopen("bench/axi_wr_cases.txt", "r");
        if (fd == 0) begin
            $display("Could not open the case file bench/axi_wr_cases.txt");
            hung = 1'b1;
        end
        while (!hung && !$feof(fd)) begin
            n = $fgets(line, fd);
            // Skip comments and blank lines
            if (n > 2 && line[0] != 8'h23) begin
                n = $sscanf(line, "%h %h %h %h %h %h %h %h", f_id, f_addr, f_len,
                            f_size, f_burst, f_base, f_strb, f_resp);
                if (n == 8) begin
                    case_no++;
                    run_case(case_no, f_id[3:0], f_addr, f_len[7:0], f_size[2:0],
                             f_burst[1:0], f_base, f_strb[3:0], f_resp[1:0]);
                end
            end
        end
        if (fd != 0) begin
            $fclose(fd);
        end
        // Responses can trail the last burst while B is stalled
        wait_resp(issued);
        if (!hung) begin
            chk.check_count(case_no);
        end
        chk.summary();
        if (!hung && chk.err_cnt == 0 && case_no > 0) begin
            $display("STATUS: PASS");
        end else begin
            $display("STATUS: FAIL");
        end
        $finish;
    end

endmodule

`default_nettype wire

// File: bench/axi_wr_checker.sv
`timescale 1ns/1ps
`default_nettype none

module axi_wr_checker (
    input  wire logic        clk,
    input  wire logic        rst_n,
    input  wire logic        i_awready,
    input  wire logic        i_wready,
    input  wire logic        i_bvalid,
    input  wire logic        i_bready,
    input  wire logic [1:0]  i_bresp,
    input  wire logic [3:0]  i_bid,
    input  wire logic [31:0] i_rd_data,
    input  wire logic [15:0] i_burst_cnt
);

    int         err_cnt  = 0;
    int         resp_cnt = 0;
    int         n_pass   = 0;
    int         n_fail   = 0;
    // Expected responses in issue order with id above resp
    logic [5:0] exp_q[$];
    logic [5:0] exp_e;

    task automatic expect_resp(input logic [3:0] id, input logic [1:0] resp);
        exp_q.push_back({id, resp});
    endtask

    task automatic flag_error(input string msg);
        $display("%s", msg);
        err_cnt++;
    endtask

    // B transfer happens on an edge with valid and ready both high
    always @(posedge clk) begin
        if (rst_n && i_bvalid && i_bready) begin
            if (exp_q.size() == 0) begin
                $display("Write response id %0h arrived with no burst outstanding", i_bid);
                err_cnt++;
            end else begin
                exp_e = exp_q.pop_front();
                if (i_bid !== exp_e[5:2]) begin
                    $display("[FAIL] t=%0t o_bid exp=%h got=%h", $time, exp_e[5:2], i_bid);
                    err_cnt++;
                end
                if (i_bresp !== exp_e[1:0]) begin
                    $display("[FAIL] t=%0t o_bresp exp=%h got=%h", $time, exp_e[1:0], i_bresp);
                    err_cnt++;
                end
                resp_cnt++;
            end
        end
    end

    task automatic check_idle();
        if (i_bvalid !== 1'b0) begin
            $display("[FAIL] t=%0t o_bvalid exp=0 got=%b", $time, i_bvalid);
            err_cnt++;
        end
        if (i_burst_cnt !== 16'd0) begin
            $display("[FAIL] t=%0t o_burst_cnt exp=0 got=%0d", $time, i_burst_cnt);
            err_cnt++;
        end
        if (i_awready !== 1'b1) begin
            $display("[FAIL] t=%0t o_awready exp=1 got=%b", $time, i_awready);
            err_cnt++;
        end
        // No burst accepted yet so W stays closed
        if (i_wready !== 1'b0) begin
            $display("[FAIL] t=%0t o_wready exp=0 got=%b", $time, i_wready);
            err_cnt++;
        end
    endtask

    // Only bytes with known content take part
    task automatic check_word(input int idx, input logic [31:0] exp, input logic [31:0] mask);
        if ((i_rd_data & mask) !== (exp & mask)) begin
            $display("[FAIL] t=%0t o_rd_data[%0d] exp=%h got=%h", $time, idx,
                     exp & mask, i_rd_data & mask);
            err_cnt++;
        end
    endtask

    task automatic check_count(input int n);
        if (i_burst_cnt !== 16'(n)) begin
            $display("[FAIL] t=%0t o_burst_cnt exp=%0d got=%0d", $time, n, i_burst_cnt);
            err_cnt++;
        end
    endtask

    task automatic end_case(input int num, input logic [3:0] id, input int e0);
        if (err_cnt == e0) begin
            n_pass++;
            $display("case %0d id %h: passed", num, id);
        end else begin
            n_fail++;
            $display("case %0d id %h: failed", num, id);
        end
    endtask

    task automatic summary();
        $display("cases passed %0d, failed %0d, failed checks %0d, responses %0d",
                 n_pass, n_fail, err_cnt, resp_cnt);
    endtask

endmodule

`default_nettype wire

// File: hdl/axi_wr_sys.sv
`timescale 1ns/1ps
`default_nettype none

module axi_wr_sys import axi_pkg::*, wr_mem_pkg::*; #(
    parameter int AW       = AXI_AW,
    parameter int DW       = AXI_DW,
    parameter int IW       = AXI_IW,
    parameter int DEPTH    = MEM_WORDS,
    parameter int HOLD_CYC = MEM_HOLD_DEF
) (
    input  wire logic                 clk,
    input  wire logic                 rst_n,

    // AW channel
    input  wire logic                 i_awvalid,
    output logic                      o_awready,
    input  wire logic [AW-1:0]        i_awaddr,
    input  wire logic [1:0]           i_awburst,
    input  wire logic [2:0]           i_awsize,
    input  wire logic [7:0]           i_awlen,
    input  wire logic [IW-1:0]        i_awid,

    // W channel
    input  wire logic                 i_wvalid,
    output logic                      o_wready,
    input  wire logic [DW-1:0]        i_wdata,
    input  wire logic [DW/8-1:0]      i_wstrb,
    input  wire logic                 i_wlast,

    // B channel
    output logic                      o_bvalid,
    input  wire logic                 i_bready,
    output logic [1:0]                o_bresp,
    output logic [IW-1:0]             o_bid,

    // Memory observation
    input  wire logic [MEM_IDX_W-1:0] i_rd_idx,
    output logic      [DW-1:0]        o_rd_data,
    output logic      [15:0]          o_burst_cnt
);

    // Component strobe link
    logic            comp_dv;
    logic [AW-1:0]   comp_addr;
    logic [DW-1:0]   comp_wdata;
    logic [DW/8-1:0] comp_wstrb;
    logic            comp_last;
    logic            comp_hld;
    logic            comp_err;

    axi_sub_wr #(
        .AW (AW),
        .DW (DW),
        .IW (IW)
    ) u_sub (
        .clk       (clk),
        .rst_n     (rst_n),
        .i_awvalid (i_awvalid),
        .o_awready (o_awready),
        .i_awaddr  (i_awaddr),
        .i_awburst (i_awburst),
        .i_awsize  (i_awsize),
        .i_awlen   (i_awlen),
        .i_awid    (i_awid),
        .i_wvalid  (i_wvalid),
        .o_wready  (o_wready),
        .i_wdata   (i_wdata),
        .i_wstrb   (i_wstrb),
        .i_wlast   (i_wlast),
        .o_bvalid  (o_bvalid),
        .i_bready  (i_bready),
        .o_bresp   (o_bresp),
        .o_bid     (o_bid),
        .o_dv      (comp_dv),
        .o_addr    (comp_addr),
        .o_wdata   (comp_wdata),
        .o_wstrb   (comp_wstrb),
        .o_last    (comp_last),
        .i_hld     (comp_hld),
        .i_err     (comp_err)
    );

    wr_mem_ep #(
        .DEPTH    (DEPTH),
        .HOLD_CYC (HOLD_CYC)
    ) u_mem (
        .clk         (clk),
        .rst_n       (rst_n),
        .i_dv        (comp_dv),
        .i_addr      (comp_addr),
        .i_wdata     (comp_wdata),
        .i_wstrb     (comp_wstrb),
        .i_last      (comp_last),
        .o_hld       (comp_hld),
        .o_err       (comp_err),
        .i_rd_idx    (i_rd_idx),
        .o_rd_data   (o_rd_data),
        .o_burst_cnt (o_burst_cnt)
    );

endmodule

`default_nettype wire

// File: hdl/wr_mem_ep.sv
`timescale 1ns/1ps
`default_nettype none

module wr_mem_ep import axi_pkg::*, wr_mem_pkg::*; #(
    parameter int DEPTH    = MEM_WORDS,
    parameter int HOLD_CYC = MEM_HOLD_DEF
) (
    input  wire logic                 clk,
    input  wire logic                 rst_n,

    // Component strobe side
    input  wire logic                 i_dv,
    input  wire logic [AXI_AW-1:0]    i_addr,
    input  wire logic [AXI_DW-1:0]    i_wdata,
    input  wire logic [AXI_DW/8-1:0]  i_wstrb,
    input  wire logic                 i_last,
    output logic                      o_hld,
    output logic                      o_err,

    // Observation
    input  wire logic [MEM_IDX_W-1:0] i_rd_idx,
    output logic      [AXI_DW-1:0]    o_rd_data,
    output logic      [15:0]          o_burst_cnt
);

    localparam int BC    = AXI_DW/8;
    localparam int BW    = $clog2(BC);
    localparam int IDX_W = $clog2(DEPTH);
    // One spare code so a zero hold still gets a legal width
    localparam int CNT_W = $clog2(HOLD_CYC + 2);

    logic [AXI_DW-1:0]    mem [DEPTH];
    logic [AXI_AW-BW-1:0] word_idx;
    logic                 in_range;
    logic                 commit;
    logic [CNT_W-1:0]     hold_cnt;

    assign word_idx = i_addr[AXI_AW-1:BW];
    assign in_range = (word_idx < (AXI_AW-BW)'(DEPTH));
    assign commit   = i_dv && !o_hld;

    // Out of range beats are flagged and then dropped
    assign o_err = i_dv && !in_range;

    // ------------------------------------------------------------------------
    // Hold counter
    // ------------------------------------------------------------------------
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            hold_cnt <= '0;
        end else if (commit) begin
            hold_cnt <= CNT_W'(HOLD_CYC);
        end else if (hold_cnt != '0) begin
            hold_cnt <= hold_cnt - CNT_W'(1);
        end
    end

    assign o_hld = (hold_cnt != '0);

    // ------------------------------------------------------------------------
    // Storage
    // ------------------------------------------------------------------------
    // Byte lanes written only where the strobe is set
    always_ff @(posedge clk) begin
        if (commit && in_range) begin
            for (int b = 0; b < BC; b++) begin
                if (i_wstrb[b]) begin
                    mem[word_idx[IDX_W-1:0]][b*8 +: 8] <= i_wdata[b*8 +: 8];
                end
            end
        end
    end

    // Read-back port, zero beyond the array
    assign o_rd_data = (int'(i_rd_idx) < DEPTH) ? mem[i_rd_idx] : '0;

    // Counts every burst end, in range or not
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            o_burst_cnt <= '0;
        end else if (commit && i_last) begin
            o_burst_cnt <= o_burst_cnt + 16'd1;
        end
    end

endmodule

`default_nettype wire

// File: hdl/axi_sub_wr.sv
`timescale 1ns/1ps
`default_nettype none

module axi_sub_wr import axi_pkg::*; #(
    parameter int AW = 32,
    parameter int DW = 32,
    parameter int IW = 4
) (
    input  wire logic            clk,
    input  wire logic            rst_n,

    // AW channel
    input  wire logic            i_awvalid,
    output logic                 o_awready,
    input  wire logic [AW-1:0]   i_awaddr,
    input  wire logic [1:0]      i_awburst,
    input  wire logic [2:0]      i_awsize,
    input  wire logic [7:0]      i_awlen,
    input  wire logic [IW-1:0]   i_awid,

    // W channel
    input  wire logic            i_wvalid,
    output logic                 o_wready,
    input  wire logic [DW-1:0]   i_wdata,
    input  wire logic [DW/8-1:0] i_wstrb,
    input  wire logic            i_wlast,

    // B channel
    output logic                 o_bvalid,
    input  wire logic            i_bready,
    output logic [1:0]           o_bresp,
    output logic [IW-1:0]        o_bid,

    // Component strobe side, one aligned word per beat
    output logic                 o_dv,
    output logic [AW-1:0]        o_addr,
    output logic [DW-1:0]        o_wdata,
    output logic [DW/8-1:0]      o_wstrb,
    output logic                 o_last,
    input  wire logic            i_hld,
    input  wire logic            i_err
);

    localparam int BW = $clog2(DW/8);

    // Request path
    axi_ctx_t   aw_ctx;
    axi_ctx_t   req_ctx;
    logic       req_valid;
    logic       req_ready;

    // Active burst
    axi_ctx_t   txn_ctx;
    logic [AW-1:0] txn_addr_nxt;
    logic       txn_active;
    logic       txn_err;
    logic       txn_final_beat;
    logic       txn_wvalid;
    logic       txn_wready;

    // Data and response payloads
    axi_wbeat_t w_beat_in;
    axi_wbeat_t w_beat_out;
    axi_bresp_t rp_data;
    axi_bresp_t b_data;
    logic       rp_valid;
    logic       rp_ready;

    // ------------------------------------------------------------------------
    // Request acceptance
    // ------------------------------------------------------------------------
    always_comb begin
        aw_ctx.addr  = i_awaddr;
        aw_ctx.burst = axi_burst_e'(i_awburst);
        aw_ctx.size  = i_awsize;
        aw_ctx.len   = i_awlen;
        aw_ctx.id    = i_awid;
    end

    skidbuffer #(
        .T          (axi_ctx_t),
        .OPT_OUTREG (1'b0)
    ) u_req_skd (
        .clk     (clk),
        .rst_n   (rst_n),
        .i_valid (i_awvalid),
        .o_ready (o_awready),
        .i_data  (aw_ctx),
        .o_valid (req_valid),
        .i_ready (req_ready),
        .o_data  (req_ctx)
    );

    // Take a new burst only with a free slot waiting in the response path
    assign req_ready = (!txn_active || (txn_final_beat && !o_bvalid)) && rp_ready;

    // Final beat of the active burst commits this cycle
    assign txn_final_beat = o_dv && !i_hld && o_last;

    // New request wins over the end of the previous one
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            txn_active <= 1'b0;
            txn_err    <= 1'b0;
        end else if (req_valid && req_ready) begin
            txn_active <= 1'b1;
            txn_err    <= 1'b0;
        end else begin
            if (txn_final_beat) begin
                txn_active <= 1'b0;
            end
            // Sticky over the whole burst
            if (o_dv && !i_hld) begin
                txn_err <= txn_err || i_err;
            end
        end
    end

    // Context loads on accept, address walks on every committed beat
    always_ff @(posedge clk) begin
        if (req_valid && req_ready) begin
            txn_ctx <= req_ctx;
        end else if (o_dv && !i_hld) begin
            txn_ctx.addr <= txn_addr_nxt;
        end
    end

    // ------------------------------------------------------------------------
    // Beat addressing
    // ------------------------------------------------------------------------
    // Full byte address feeds the walker, narrow sizes need the low bits
    axi_addr #(
        .AW (AW),
        .DW (DW)
    ) u_axi_addr (
        .i_last_addr (txn_ctx.addr),
        .i_size      (txn_ctx.size),
        .i_burst     (txn_ctx.burst),
        .i_len       (txn_ctx.len),
        .o_next_addr (txn_addr_nxt)
    );

    // Component only sees word addresses
    assign o_addr = {txn_ctx.addr[AW-1:BW], BW'(0)};

    // ------------------------------------------------------------------------
    // Write data
    // ------------------------------------------------------------------------
    // W is held off until a burst is active
    assign txn_wvalid = i_wvalid && txn_active;
    assign o_wready   = txn_wready && txn_active;

    always_comb begin
        w_beat_in.data = i_wdata;
        w_beat_in.strb = i_wstrb;
        w_beat_in.last = i_wlast;
    end

    skidbuffer #(
        .T          (axi_wbeat_t),
        .OPT_OUTREG (1'b0)
    ) u_dat_skd (
        .clk     (clk),
        .rst_n   (rst_n),
        .i_valid (txn_wvalid),
        .o_ready (txn_wready),
        .i_data  (w_beat_in),
        .o_valid (o_dv),
        .i_ready (!i_hld),
        .o_data  (w_beat_out)
    );

    assign o_wdata = w_beat_out.data;
    assign o_wstrb = w_beat_out.strb;
    assign o_last  = w_beat_out.last;

    // ------------------------------------------------------------------------
    // Write response
    // ------------------------------------------------------------------------
    // Error of the final beat itself counts too
    always_comb begin
        rp_valid     = txn_final_beat;
        rp_data.resp = (txn_err || i_err) ? AXI_RESP_SLVERR : AXI_RESP_OKAY;
        rp_data.id   = txn_ctx.id;
    end

    // Registered output, skid entry absorbs one response under B stall
    skidbuffer #(
        .T          (axi_bresp_t),
        .OPT_OUTREG (1'b1)
    ) u_rsp_skd (
        .clk     (clk),
        .rst_n   (rst_n),
        .i_valid (rp_valid),
        .o_ready (rp_ready),
        .i_data  (rp_data),
        .o_valid (o_bvalid),
        .i_ready (i_bready),
        .o_data  (b_data)
    );

    assign o_bresp = b_data.resp;
    assign o_bid   = b_data.id;

endmodule

`default_nettype wire

// File: hdl/axi_addr.sv
`timescale 1ns/1ps
`default_nettype none

module axi_addr import axi_pkg::*; #(
    parameter int AW = 32,
    parameter int DW = 32
) (
    input  wire logic [AW-1:0] i_last_addr,
    input  wire logic [2:0]    i_size,
    input  wire axi_burst_e    i_burst,
    input  wire logic [7:0]    i_len,
    output logic      [AW-1:0] o_next_addr
);

    // Widest legal transfer is one full data word
    localparam int BW = $clog2(DW/8);

    logic [2:0]    size_eff;
    logic [AW-1:0] beat_bytes;
    logic [AW-1:0] addr_algn;
    logic [AW-1:0] addr_incr;
    logic [AW-1:0] wrap_mask;

    // Oversized AxSIZE is clipped to the bus width
    assign size_eff   = (i_size > 3'(BW)) ? 3'(BW) : i_size;
    assign beat_bytes = AW'(1) << size_eff;

    // Unaligned start, later beats snap to the transfer size
    assign addr_algn  = i_last_addr & ~(beat_bytes - AW'(1));
    assign addr_incr  = addr_algn + beat_bytes;

    // Wrap window is (len+1) beats, len is 1, 3, 7 or 15 for WRAP
    assign wrap_mask  = (beat_bytes * (AW'(i_len) + AW'(1))) - AW'(1);

    always_comb begin
        case (i_burst)
            AXI_BURST_FIXED: o_next_addr = i_last_addr;
            AXI_BURST_INCR:  o_next_addr = addr_incr;
            // Upper bits stay put, lower bits roll over inside the window
            AXI_BURST_WRAP:  o_next_addr = (i_last_addr & ~wrap_mask) |
                                           (addr_incr & wrap_mask);
            // Reserved encoding, address does not move
            default:         o_next_addr = i_last_addr;
        endcase
    end

endmodule

`default_nettype wire

// File: hdl/skidbuffer.sv
`timescale 1ns/1ps
`default_nettype none

module skidbuffer #(
    parameter type T          = logic,
    parameter bit  OPT_OUTREG = 1'b0
) (
    input  wire logic clk,
    input  wire logic rst_n,

    // Upstream side
    input  wire logic i_valid,
    output logic      o_ready,
    input  wire T     i_data,

    // Downstream side
    output logic      o_valid,
    input  wire logic i_ready,
    output T          o_data
);

    // Skid entry, filled when a beat is taken while downstream stalls
    logic r_valid;
    T     r_data;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            r_valid <= 1'b0;
        end else if (i_valid && o_ready && o_valid && !i_ready) begin
            r_valid <= 1'b1;
        end else if (i_ready) begin
            r_valid <= 1'b0;
        end
    end

    // Payload follows the input whenever the entry is free
    always_ff @(posedge clk) begin
        if (o_ready) begin
            r_data <= i_data;
        end
    end

    // Upstream ready is a flop, so no combinational path back
    assign o_ready = !r_valid;

    // ------------------------------------------------------------------------
    // Output stage
    // ------------------------------------------------------------------------
    generate
        if (OPT_OUTREG) begin : g_outreg
            logic ro_valid;
            T     ro_data;

            // Load whenever the output register is empty or being drained
            always_ff @(posedge clk or negedge rst_n) begin
                if (!rst_n) begin
                    ro_valid <= 1'b0;
                end else if (!o_valid || i_ready) begin
                    ro_valid <= i_valid || r_valid;
                end
            end

            // Skid entry has priority since it is older
            always_ff @(posedge clk) begin
                if (!o_valid || i_ready) begin
                    ro_data <= r_valid ? r_data : i_data;
                end
            end

            assign o_valid = ro_valid;
            assign o_data  = ro_data;
        end else begin : g_pass
            // Straight through unless the skid entry holds a beat
            assign o_valid = i_valid || r_valid;
            assign o_data  = r_valid ? r_data : i_data;
        end
    endgenerate

endmodule

`default_nettype wire

// File: hdl/wr_mem_pkg.sv
`default_nettype none

package wr_mem_pkg;

    // Endpoint depth in 32-bit words
    localparam int MEM_WORDS = 64;

    // Stall cycles inserted after every accepted beat
    localparam int MEM_HOLD_DEF = 1;

    // Read-back index width
    localparam int MEM_IDX_W = $clog2(MEM_WORDS);

endpackage

`default_nettype wire

// File: hdl/axi_pkg.sv
`default_nettype none

package axi_pkg;

    // Bus geometry shared by the skid buffer payloads
    localparam int AXI_AW = 32;
    localparam int AXI_DW = 32;
    localparam int AXI_IW = 4;

    // AxBURST encoding with value 3 reserved
    typedef enum logic [1:0] {
        AXI_BURST_FIXED = 2'b00,
        AXI_BURST_INCR  = 2'b01,
        AXI_BURST_WRAP  = 2'b10
    } axi_burst_e;

    // xRESP encoding
    typedef enum logic [1:0] {
        AXI_RESP_OKAY   = 2'b00,
        AXI_RESP_EXOKAY = 2'b01,
        AXI_RESP_SLVERR = 2'b10,
        AXI_RESP_DECERR = 2'b11
    } axi_resp_e;

    // Burst context as captured from the AW channel
    typedef struct packed {
        logic [AXI_AW-1:0] addr;
        axi_burst_e        burst;
        logic [2:0]        size;
        logic [7:0]        len;
        logic [AXI_IW-1:0] id;
    } axi_ctx_t;

    // One W beat
    typedef struct packed {
        logic [AXI_DW-1:0]   data;
        logic [AXI_DW/8-1:0] strb;
        logic                last;
    } axi_wbeat_t;

    // One B response
    typedef struct packed {
        axi_resp_e         resp;
        logic [AXI_IW-1:0] id;
    } axi_bresp_t;

endpackage

`default_nettype wire
